// ==== scrolling_message_display.f ====
+incdir+hw
hw/display_pkg.sv
hw/tick_divider.sv
hw/segment_decoder.sv
hw/message_scroller.sv
hw/digit_scanner.sv
hw/scrolling_message_display.sv
verification/scrolling_message_display_sva.sv
verification/scrolling_message_display_tb.sv

// ==== Makefile ====
# Verilator build and run of the scrolling message display testbench.

TOP := scrolling_message_display_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f scrolling_message_display.f --Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Test failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Test ended without a result line, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/scrolling_message_display_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "display_defs.svh"

module scrolling_message_display_tb;

    localparam int SCROLL_DIVIDE   = 64;
    localparam int REFRESH_DIVIDE  = 4;
    localparam int RESET_CYCLES    = 8;
    localparam int PASS_CYCLES     = `SCROLL_STEPS * SCROLL_DIVIDE;
    localparam int WATCHDOG_CYCLES = 3 * PASS_CYCLES + 2 * RESET_CYCLES + 256;

    // ************************************************************************
    // Reference data
    // ************************************************************************

    localparam logic [4:0] MESSAGE [`MESSAGE_LENGTH] = '{
        5'd11, 5'd17, 5'd12, 5'd14, 5'd8,  5'd13, 5'd7,
        5'd10, 5'd14, 5'd0,  5'd13, 5'd3,  5'd10, 5'd5,
        5'd2,  5'd15, 5'd13, 5'd1,  5'd17, 5'd4,  5'd10,
        5'd14, 5'd9,  5'd13, 5'd10, 5'd1,  5'd6,  5'd15
    };

    // Active-low segments a to g for each character code.
    localparam logic [6:0] GLYPHS [18] = '{
        7'b1000100, 7'b0100000, 7'b1001111, 7'b1110001,
        7'b0101011, 7'b1101010, 7'b0011000, 7'b1111010,
        7'b0100100, 7'b0001111, 7'b0001000, 7'b0000000,
        7'b0110001, 7'b1111111, 7'b0110000, 7'b0111000,
        7'b1111111, 7'b1111110
    };

    // Active-low digit enables, leftmost digit first.
    localparam logic [3:0] ENABLE_PATTERNS [`DIGIT_COUNT] = '{
        4'b0111, 4'b1011, 4'b1101, 4'b1110
    };

    logic       S_clk = 1'b0;
    logic       reset;
    logic [3:0] digit_enable_n;
    logic [6:0] segment_n;

    int live_edges;
    int checks;
    int errors;
    int mid_offset;
    int assertion_failures;

    scrolling_message_display #(
        .SCROLL_DIVIDE  (SCROLL_DIVIDE),
        .REFRESH_DIVIDE (REFRESH_DIVIDE)
    ) uut (
        .S_clk          (S_clk),
        .reset          (reset),
        .digit_enable_n (digit_enable_n),
        .segment_n      (segment_n)
    );

    always #5 S_clk = ~S_clk;

    function automatic logic [4:0] padded_char(input int position);
        if (position < `DIGIT_COUNT - 1 || position >= `DIGIT_COUNT - 1 + `MESSAGE_LENGTH)
            return `BLANK_CHAR;
        return MESSAGE[5'(position - (`DIGIT_COUNT - 1))];
    endfunction

    function automatic logic [6:0] glyph_segments(input logic [4:0] code);
        if (code > 5'd17)
            return 7'b1111111;
        return GLYPHS[code];
    endfunction

    // Edges seen by the DUT with reset low. The count is zero right after a release.
    always @(posedge S_clk)
    begin
        if (reset)
            live_edges <= 0;
        else
            live_edges <= live_edges + 1;
    end

    // ************************************************************************
    // Output checks
    // ************************************************************************

    task automatic check_outputs();
        int         refresh_count;
        int         digit;
        int         step;
        logic [3:0] expected_enable;
        logic [6:0] expected_segments;
        checks++;
        if (reset || live_edges < REFRESH_DIVIDE)
        begin
            expected_enable   = 4'b1111;
            expected_segments = 7'b1111111;
            step              = 0;
            digit             = 0;
        end
        else
        begin
            refresh_count = live_edges / REFRESH_DIVIDE;
            digit         = (refresh_count - 1) % `DIGIT_COUNT;
            // The scanner took the window as it stood just before its last refresh edge.
            step = ((refresh_count * REFRESH_DIVIDE - 1) / SCROLL_DIVIDE) % `SCROLL_STEPS;
            expected_enable   = ENABLE_PATTERNS[2'(digit)];
            expected_segments = glyph_segments(padded_char(step + digit));
        end
        enable_check: assert (digit_enable_n == expected_enable)
        else
        begin
            errors++;
            $display("[FAIL] %0t: digit_enable_n is %b, expected %b (step %0d, digit %0d)",
                     $time, digit_enable_n, expected_enable, step, digit);
        end
        segment_check: assert (segment_n == expected_segments)
        else
        begin
            errors++;
            $display("[FAIL] %0t: segment_n is %b, expected %b (step %0d, digit %0d)",
                     $time, segment_n, expected_segments, step, digit);
        end
    endtask

    always @(negedge S_clk)
    begin
        check_outputs();
    end

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge S_clk);
        reset <= 1'b0;
    endtask

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    initial
    begin
        reset      = 1'b1;
        live_edges = 0;
        checks     = 0;
        errors     = 0;
        void'($urandom(32'h689c));
        mid_offset = $urandom % 64;

        repeat (RESET_CYCLES) @(posedge S_clk);
        reset <= 1'b0;

        // Two full passes and then a reset somewhere in the middle of the third.
        repeat (2 * PASS_CYCLES + PASS_CYCLES / 2 + mid_offset) @(posedge S_clk);
        apply_reset();
        repeat (4 * SCROLL_DIVIDE + 20) @(posedge S_clk);
        #1;

        assertion_failures = uut.enable_checks.failure_count;
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 checks, errors, assertion_failures);
        if (errors == 0 && assertion_failures == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * 10);
        $display("Timeout: the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/scrolling_message_display_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module scrolling_message_display_sva #(
    parameter int REFRESH_DIVIDE = 4
) (
    input logic       S_clk,
    input logic       reset,
    input logic [3:0] digit_enable_n
);

    int edge_phase;
    int failure_count = 0;

    function automatic logic [3:0] rotate_right(input logic [3:0] value);
        return {value[0], value[3:1]};
    endfunction

    // Edges since reset release modulo the refresh period.
    // A phase of zero follows an edge where a refresh tick lands.
    always_ff @(posedge S_clk or posedge reset)
    begin
        if (reset)
            edge_phase <= 0;
        else if (edge_phase == REFRESH_DIVIDE - 1)
            edge_phase <= 0;
        else
            edge_phase <= edge_phase + 1;
    end

    // ************************************************************************
    // Digit enable properties
    // ************************************************************************

    enables_valid: assert property (@(posedge S_clk) disable iff (reset)
        $onehot(~digit_enable_n) || digit_enable_n == 4'b1111)
    else
    begin
        failure_count++;
        $error("digit_enable_n %b has more than one digit on", digit_enable_n);
    end

    // Once scanning has started a digit is on in every cycle.
    scan_keeps_running: assert property (@(posedge S_clk) disable iff (reset)
        digit_enable_n != 4'b1111 |=> $onehot(~digit_enable_n))
    else
    begin
        failure_count++;
        $error("digit scan stopped, digit_enable_n is %b", digit_enable_n);
    end

    scan_starts_left: assert property (@(posedge S_clk) disable iff (reset)
        $past(digit_enable_n) == 4'b1111 && digit_enable_n != 4'b1111
        |-> digit_enable_n == 4'b0111)
    else
    begin
        failure_count++;
        $error("first enabled digit is %b, not the leftmost", digit_enable_n);
    end

    scan_order: assert property (@(posedge S_clk) disable iff (reset)
        $past(digit_enable_n) != 4'b1111 && $changed(digit_enable_n)
        |-> digit_enable_n == rotate_right($past(digit_enable_n)))
    else
    begin
        failure_count++;
        $error("digit_enable_n moved out of order to %b", digit_enable_n);
    end

    scan_on_refresh: assert property (@(posedge S_clk) disable iff (reset)
        $changed(digit_enable_n) |-> edge_phase == 0)
    else
    begin
        failure_count++;
        $error("digit_enable_n changed between refresh edges");
    end

endmodule

bind scrolling_message_display scrolling_message_display_sva #(
    .REFRESH_DIVIDE (REFRESH_DIVIDE)
) enable_checks (
    .S_clk          (S_clk),
    .reset          (reset),
    .digit_enable_n (digit_enable_n)
);

`default_nettype wire

// ==== hw/scrolling_message_display.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "display_defs.svh"

module scrolling_message_display #(
    parameter int SCROLL_DIVIDE  = `SCROLL_DIVIDE,
    parameter int REFRESH_DIVIDE = `REFRESH_DIVIDE
) (
    input  logic                    S_clk,
    input  logic                    reset,
    output logic [`DIGIT_COUNT-1:0] digit_enable_n,
    output logic [6:0]              segment_n
);

    import display_pkg::*;

    logic          scroll_tick;
    logic          refresh_tick;
    digit_window_t window;

    // ************************************************************************
    // Timing ticks
    // ************************************************************************

    tick_divider #(
        .DIVIDE (SCROLL_DIVIDE)
    ) scroll_div (
        .S_clk (S_clk),
        .reset (reset),
        .tick  (scroll_tick)
    );

    tick_divider #(
        .DIVIDE (REFRESH_DIVIDE)
    ) refresh_div (
        .S_clk (S_clk),
        .reset (reset),
        .tick  (refresh_tick)
    );

    // ************************************************************************
    // Message window and digit scan
    // ************************************************************************

    message_scroller u_scroller (
        .S_clk       (S_clk),
        .reset       (reset),
        .scroll_tick (scroll_tick),
        .window      (window)
    );

    digit_scanner u_scanner (
        .S_clk          (S_clk),
        .reset          (reset),
        .refresh_tick   (refresh_tick),
        .window         (window),
        .digit_enable_n (digit_enable_n),
        .segment_n      (segment_n)
    );

endmodule

`default_nettype wire

// ==== hw/digit_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "display_defs.svh"

module digit_scanner (
    input  logic                       S_clk,
    input  logic                       reset,
    input  logic                       refresh_tick,
    input  display_pkg::digit_window_t window,
    output logic [`DIGIT_COUNT-1:0]    digit_enable_n,
    output logic [6:0]                 segment_n
);

    import display_pkg::*;

    localparam int INDEX_WIDTH = $clog2(`DIGIT_COUNT);
    localparam logic [`DIGIT_COUNT-1:0] LEFT_DIGIT = {1'b1, {(`DIGIT_COUNT - 1){1'b0}}};

    logic [INDEX_WIDTH-1:0] digit_index;
    char_code_t             selected_char;
    char_code_t             shown_char;

    always_comb
    begin
        case (digit_index)
            2'd0:    selected_char = window.first;
            2'd1:    selected_char = window.second;
            2'd2:    selected_char = window.third;
            default: selected_char = window.fourth;
        endcase
    end

    // ************************************************************************
    // Digit scan
    // ************************************************************************

    // Enable and character are registered together, so the decoded
    // segments switch on the same edge as the digit.
    always_ff @(posedge S_clk or posedge reset)
    begin
        if (reset)
        begin
            digit_index    <= '0;
            digit_enable_n <= '1;
            shown_char     <= `BLANK_CHAR;
        end
        else if (refresh_tick)
        begin
            digit_index    <= digit_index + 1'b1;
            digit_enable_n <= ~(LEFT_DIGIT >> digit_index);
            shown_char     <= selected_char;
        end
    end

    segment_decoder u_decoder (
        .char_code (shown_char),
        .segment_n (segment_n)
    );

endmodule

`default_nettype wire

// ==== hw/message_scroller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "display_defs.svh"

module message_scroller (
    input  logic                       S_clk,
    input  logic                       reset,
    input  logic                       scroll_tick,
    output display_pkg::digit_window_t window
);

    import display_pkg::*;

    localparam int PADDED_LENGTH = `MESSAGE_LENGTH + 2 * `DIGIT_COUNT - 1;
    localparam int STEP_WIDTH    = $clog2(`SCROLL_STEPS);
    localparam int INDEX_WIDTH   = $clog2(PADDED_LENGTH);

    // ************************************************************************
    // Message table
    // ************************************************************************

    // The message enters from the right behind three blanks and leaves
    // to the left ahead of four blanks, so step 31 shows an empty display.
    localparam char_code_t PADDED [PADDED_LENGTH] = '{
        `BLANK_CHAR, `BLANK_CHAR, `BLANK_CHAR,
        5'd11, 5'd17, 5'd12, 5'd14, 5'd8,  5'd13, 5'd7,
        5'd10, 5'd14, 5'd0,  5'd13, 5'd3,  5'd10, 5'd5,
        5'd2,  5'd15, 5'd13, 5'd1,  5'd17, 5'd4,  5'd10,
        5'd14, 5'd9,  5'd13, 5'd10, 5'd1,  5'd6,  5'd15,
        `BLANK_CHAR, `BLANK_CHAR, `BLANK_CHAR, `BLANK_CHAR
    };

    logic [STEP_WIDTH-1:0] step;
    logic [STEP_WIDTH-1:0] step_next;

    function automatic digit_window_t window_at(input logic [STEP_WIDTH-1:0] k);
        logic [INDEX_WIDTH-1:0] base;
        digit_window_t          w;
        base     = INDEX_WIDTH'(k);
        w.first  = PADDED[base];
        w.second = PADDED[base + INDEX_WIDTH'(1)];
        w.third  = PADDED[base + INDEX_WIDTH'(2)];
        w.fourth = PADDED[base + INDEX_WIDTH'(3)];
        return w;
    endfunction

    // ************************************************************************
    // Step counter and window register
    // ************************************************************************

    always_comb
    begin
        step_next = step;
        if (scroll_tick)
        begin
            if (step == STEP_WIDTH'(`SCROLL_STEPS - 1))
                step_next = '0;
            else
                step_next = step + 1'b1;
        end
    end

    // The window is loaded from the next step, so it moves on the same edge
    // as the counter.
    always_ff @(posedge S_clk or posedge reset)
    begin
        if (reset)
        begin
            step   <= '0;
            window <= '{`BLANK_CHAR, `BLANK_CHAR, `BLANK_CHAR, `BLANK_CHAR};
        end
        else
        begin
            step   <= step_next;
            window <= window_at(step_next);
        end
    end

endmodule

`default_nettype wire

// ==== hw/segment_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module segment_decoder (
    input  display_pkg::char_code_t char_code,
    output logic [6:0]              segment_n
);

    // Segments are active low. Bit 6 is segment a and bit 0 is segment g.
    always_comb
    begin
        case (char_code)
            5'd0:    segment_n = 7'h44;
            5'd1:    segment_n = 7'h20;
            5'd2:    segment_n = 7'h4f;
            5'd3:    segment_n = 7'h71;
            5'd4:    segment_n = 7'h2b;
            5'd5:    segment_n = 7'h6a;
            5'd6:    segment_n = 7'h18;
            5'd7:    segment_n = 7'h7a;
            5'd8:    segment_n = 7'h24;
            5'd9:    segment_n = 7'h0f;
            5'd10:   segment_n = 7'h08;
            5'd11:   segment_n = 7'h00;
            5'd12:   segment_n = 7'h31;
            5'd13:   segment_n = 7'h7f;
            5'd14:   segment_n = 7'h30;
            5'd15:   segment_n = 7'h38;
            // A dash lights only the middle bar.
            5'd17:   segment_n = 7'b1111110;
            default: segment_n = 7'h7f;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/tick_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module tick_divider #(
    parameter int DIVIDE = 4
) (
    input  logic S_clk,
    input  logic reset,
    output logic tick
);

    localparam int COUNT_WIDTH = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;
    localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(DIVIDE - 1);

    logic [COUNT_WIDTH-1:0] count;

    always_ff @(posedge S_clk or posedge reset)
    begin
        if (reset)
            count <= '0;
        else if (count == LAST_COUNT)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    // The pulse is seen by the consumers on the edge where the count wraps.
    assign tick = (count == LAST_COUNT);

endmodule

`default_nettype wire

// ==== hw/display_pkg.sv ====
`default_nettype none

package display_pkg;

    // ************************************************************************
    // Character and window types
    // ************************************************************************

    // Codes 0 to 15 and 17 have glyphs and 13 is the blank.
    // Any code without a glyph shows as blank.
    typedef logic [4:0] char_code_t;

    // Four characters as seen on the display. The first is the leftmost digit.
    typedef struct packed {
        char_code_t first;
        char_code_t second;
        char_code_t third;
        char_code_t fourth;
    } digit_window_t;

endpackage

`default_nettype wire

// ==== hw/display_defs.svh ====
`ifndef DISPLAY_DEFS_SVH
`define DISPLAY_DEFS_SVH

// ************************************************************************
// Display timing and message geometry
// ************************************************************************

// Clock cycles between scroll steps. That is about half a second at 100 MHz.
`define SCROLL_DIVIDE 50_000_000

// Clock cycles between digit refreshes.
`define REFRESH_DIVIDE 50_000

// Number of seven-segment digits on the board.
`define DIGIT_COUNT 4

// Characters in the fixed message.
`define MESSAGE_LENGTH 28

// Character code that lights no segment.
`define BLANK_CHAR 5'd13

// Distinct windows in one pass of the message.
`define SCROLL_STEPS 32

`endif
